// ==== all.f ====
hdl/bp_pkg.sv
hdl/bp_update_if.sv
hdl/pht.sv
hdl/btb.sv
hdl/direction_predictor.sv
hdl/predict_stats.sv
hdl/branch_predictor.sv
verification/branch_predictor_checker.sv
verification/tb_branch_predictor.sv

// ==== hdl/bp_pkg.sv ====
package bp_pkg;

    localparam int addr_bits = 32;
    localparam int pc_lsb = 2;                          // instructions are word aligned
    localparam int tag_field_bits = addr_bits - pc_lsb; // widest tag any btb size can need

    typedef logic [addr_bits-1:0] addr_t;
    typedef logic [tag_field_bits-1:0] tag_field_t;

    // control-flow opcodes tracked by the predictor
    typedef enum logic [1:0] {
        br   = 2'd0,
        jal  = 2'd1,
        jalr = 2'd2
    } branch_kind_t;

    // two-bit saturating counter whose msb is the prediction
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } counter_t;

    typedef struct packed {
        logic         valid;
        tag_field_t   tag;    // zero extended above the real tag width
        addr_t        target;
        branch_kind_t kind;
    } btb_entry_t;

endpackage : bp_pkg

// ==== hdl/bp_update_if.sv ====
`timescale 1ns/1ns

interface bp_update_if
    import bp_pkg::*;
();

    logic         update_valid;   // single-cycle strobe that is always accepted
    addr_t        pc;
    logic         taken;
    addr_t        target;
    branch_kind_t kind;
    logic         dir_taken;      // direction predictor's guess for pc

    modport consumer (
        input update_valid, pc, taken, target, kind, dir_taken
    );

    // the direction predictor reports its own guess back onto the bus
    modport predictor (
        input  update_valid, pc, taken, target, kind,
        output dir_taken
    );

endinterface : bp_update_if

// ==== hdl/branch_predictor.sv ====
`timescale 1ns/1ns

module branch_predictor
    import bp_pkg::*;
#(
    parameter int btb_index_bits     = 4,
    parameter int hist_bits          = 4,
    parameter int bht_index_bits     = 4,
    parameter int chooser_index_bits = 4,
    parameter int stat_width         = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  addr_t                 lookup_pc,
    output logic                  pred_hit,
    output addr_t                 pred_target,
    output branch_kind_t          pred_kind,
    output logic                  pred_taken,
    input  logic                  update_valid,
    input  addr_t                 update_pc,
    input  logic                  update_taken,
    input  addr_t                 update_target,
    input  branch_kind_t          update_kind,
    output logic [stat_width-1:0] update_count,
    output logic [stat_width-1:0] correct_count
);

    bp_update_if upd ();

    logic dir_raw;   // counter direction without the btb

    assign upd.update_valid = update_valid;
    assign upd.pc           = update_pc;
    assign upd.taken        = update_taken;
    assign upd.target       = update_target;
    assign upd.kind         = update_kind;

    btb #(.btb_index_bits(btb_index_bits)) i_btb (
        .clk(clk), .rst(rst),
        .lookup_pc(lookup_pc), .upd(upd.consumer),
        .hit(pred_hit), .target(pred_target), .kind(pred_kind)
    );

    direction_predictor #(
        .hist_bits(hist_bits),
        .bht_index_bits(bht_index_bits),
        .chooser_index_bits(chooser_index_bits)
    ) i_direction_predictor (
        .clk(clk), .rst(rst),
        .lookup_pc(lookup_pc), .upd(upd.predictor),
        .taken(dir_raw)
    );

    predict_stats #(.stat_width(stat_width)) i_predict_stats (
        .clk(clk), .rst(rst),
        .upd(upd.consumer),
        .update_count(update_count), .correct_count(correct_count)
    );

    // jumps always go, branches follow the counters, misses fall through
    assign pred_taken = pred_hit && ((pred_kind != br) || dir_raw);

endmodule : branch_predictor

// ==== hdl/btb.sv ====
`timescale 1ns/1ns

module btb
    import bp_pkg::*;
#(
    parameter int btb_index_bits = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  addr_t            lookup_pc,
    bp_update_if.consumer    upd,
    output logic             hit,
    output addr_t            target,
    output branch_kind_t     kind
);

    localparam int depth = 2 ** btb_index_bits;
    localparam int tag_bits = addr_bits - pc_lsb - btb_index_bits;

    btb_entry_t entries [depth];

    logic [btb_index_bits-1:0] rd_index;
    logic [tag_bits-1:0]       rd_tag;
    btb_entry_t                rd_entry;

    logic [btb_index_bits-1:0] wr_index;
    logic [tag_bits-1:0]       wr_tag;
    btb_entry_t                wr_entry;

    // lookup side
    assign rd_index = lookup_pc[pc_lsb +: btb_index_bits];
    assign rd_tag   = lookup_pc[addr_bits-1 -: tag_bits];
    assign rd_entry = entries[rd_index];

    assign hit    = rd_entry.valid && (rd_entry.tag == tag_field_t'(rd_tag));
    assign target = rd_entry.target;
    assign kind   = rd_entry.kind;

    // update side
    assign wr_index = upd.pc[pc_lsb +: btb_index_bits];
    assign wr_tag   = upd.pc[addr_bits-1 -: tag_bits];

    always_comb begin
        wr_entry.valid  = 1'b1;
        wr_entry.tag    = tag_field_t'(wr_tag);
        wr_entry.kind   = upd.kind;
        wr_entry.target = upd.target;
        if (upd.kind == jalr) begin
            wr_entry.target = {upd.target[addr_bits-1:1], 1'b0};   // jalr lsb is always zero
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                entries[i].valid <= 1'b0;   // payload left as is
            end
        end else if (upd.update_valid) begin
            entries[wr_index] <= wr_entry;
        end
    end

endmodule : btb

// ==== hdl/direction_predictor.sv ====
`timescale 1ns/1ns

module direction_predictor
    import bp_pkg::*;
#(
    parameter int hist_bits          = 4,
    parameter int bht_index_bits     = 4,
    parameter int chooser_index_bits = 4
) (
    input  logic          clk,
    input  logic          rst,
    input  addr_t         lookup_pc,
    bp_update_if.predictor upd,
    output logic          taken
);

    localparam int bht_depth = 2 ** bht_index_bits;

    logic [hist_bits-1:0] ghr_q;
    logic [hist_bits-1:0] bht_q [bht_depth];

    logic [bht_index_bits-1:0]     lk_bht_idx;
    logic [bht_index_bits-1:0]     up_bht_idx;
    logic [chooser_index_bits-1:0] lk_ch_idx;
    logic [chooser_index_bits-1:0] up_ch_idx;
    logic [hist_bits-1:0]          local_rindex;
    logic [hist_bits-1:0]          local_windex;
    logic [chooser_index_bits-1:0] chooser_rindex;

    counter_t global_state;
    counter_t local_state;
    counter_t chooser_state;

    logic global_pred;
    logic local_pred;
    logic use_global;
    logic train_br;
    logic global_right;
    logic local_right;

    assign lk_bht_idx = lookup_pc[pc_lsb +: bht_index_bits];
    assign up_bht_idx = upd.pc[pc_lsb +: bht_index_bits];
    assign lk_ch_idx  = lookup_pc[pc_lsb +: chooser_index_bits];
    assign up_ch_idx  = upd.pc[pc_lsb +: chooser_index_bits];

    // an update owns the per-address read ports for its cycle
    assign local_rindex   = upd.update_valid ? bht_q[up_bht_idx] : bht_q[lk_bht_idx];
    assign local_windex   = bht_q[up_bht_idx];
    assign chooser_rindex = upd.update_valid ? up_ch_idx : lk_ch_idx;

    pht #(.index_bits(hist_bits)) i_global_pht (
        .clk(clk), .rst(rst),
        .rindex(ghr_q), .rstate(global_state),
        .train_valid(train_br), .windex(ghr_q), .train_up(upd.taken)
    );

    pht #(.index_bits(hist_bits)) i_local_pht (
        .clk(clk), .rst(rst),
        .rindex(local_rindex), .rstate(local_state),
        .train_valid(train_br), .windex(local_windex), .train_up(upd.taken)
    );

    pht #(.index_bits(chooser_index_bits)) i_chooser_pht (
        .clk(clk), .rst(rst),
        .rindex(chooser_rindex), .rstate(chooser_state),
        .train_valid(train_br && (global_right != local_right)),
        .windex(up_ch_idx), .train_up(global_right)   // up means toward global
    );

    assign global_pred = global_state inside {weak_taken, strong_taken};
    assign local_pred  = local_state inside {weak_taken, strong_taken};
    assign use_global  = chooser_state inside {weak_taken, strong_taken};

    assign taken         = use_global ? global_pred : local_pred;
    assign upd.dir_taken = taken;

    assign train_br     = upd.update_valid && (upd.kind == br);
    assign global_right = (global_pred == upd.taken);
    assign local_right  = (local_pred == upd.taken);

    always_ff @(posedge clk) begin
        if (rst) begin
            ghr_q <= '0;
            for (int i = 0; i < bht_depth; i++) begin
                bht_q[i] <= '0;
            end
        end else if (train_br) begin
            ghr_q             <= {ghr_q[hist_bits-2:0], upd.taken};
            bht_q[up_bht_idx] <= {bht_q[up_bht_idx][hist_bits-2:0], upd.taken};
        end
    end

endmodule : direction_predictor

// ==== hdl/pht.sv ====
`timescale 1ns/1ns

module pht
    import bp_pkg::*;
#(
    parameter int index_bits = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [index_bits-1:0] rindex,
    output counter_t              rstate,
    input  logic                  train_valid,
    input  logic [index_bits-1:0] windex,
    input  logic                  train_up
);

    localparam int depth = 2 ** index_bits;

    counter_t table_q [depth];
    counter_t cur_state;
    counter_t next_state;

    assign rstate = table_q[rindex];   // combinational read

    always_comb begin
        cur_state = table_q[windex];
        case (cur_state)
            strong_not_taken: next_state = train_up ? weak_not_taken : strong_not_taken;
            weak_not_taken:   next_state = train_up ? weak_taken : strong_not_taken;
            weak_taken:       next_state = train_up ? strong_taken : weak_not_taken;
            default:          next_state = train_up ? strong_taken : weak_taken;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                table_q[i] <= weak_not_taken;
            end
        end else if (train_valid) begin
            table_q[windex] <= next_state;   // saturating step
        end
    end

endmodule : pht

// ==== hdl/predict_stats.sv ====
`timescale 1ns/1ns

module predict_stats
    import bp_pkg::*;
#(
    parameter int stat_width = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    bp_update_if.consumer         upd,
    output logic [stat_width-1:0] update_count,
    output logic [stat_width-1:0] correct_count
);

    logic count_update;
    logic count_correct;

    // both counters stick at all ones
    assign count_update  = upd.update_valid && (update_count != '1);
    assign count_correct = upd.update_valid && (upd.kind == br) &&
                           (upd.taken == upd.dir_taken) && (correct_count != '1);

    always_ff @(posedge clk) begin
        if (rst) begin
            update_count  <= '0;
            correct_count <= '0;
        end else begin
            if (count_update) begin
                update_count <= update_count + 1'b1;     // every resolved update
            end
            if (count_correct) begin
                correct_count <= correct_count + 1'b1;   // br guessed right
            end
        end
    end

endmodule : predict_stats

// ==== run.sh ====
#!/usr/bin/env bash
# build the branch predictor testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_branch_predictor -f all.f -o tb_branch_predictor
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_branch_predictor +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$log"; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation passed"
exit 0

// ==== verification/branch_predictor_checker.sv ====
`timescale 1ns/1ns

module branch_predictor_checker
    import bp_pkg::*;
#(
    parameter int stat_width = 16
) (
    input logic                  clk,
    input logic                  rst,
    input logic                  pred_hit,
    input branch_kind_t          pred_kind,
    input logic                  pred_taken,
    input logic                  update_valid,
    input logic [stat_width-1:0] update_count,
    input logic [stat_width-1:0] correct_count
);

    int unsigned assert_errors = 0;

    jump_taken: assert property (@(posedge clk) disable iff (rst)
        (pred_hit && pred_kind != br) |-> pred_taken)
        else begin
            $error("jump hit without a taken prediction");
            assert_errors++;
        end

    miss_not_taken: assert property (@(posedge clk) disable iff (rst)
        !pred_hit |-> !pred_taken)
        else begin
            $error("taken prediction on a miss");
            assert_errors++;
        end

    count_step: assert property (@(posedge clk) disable iff (rst)
        (update_valid && update_count != '1) |=> update_count == $past(update_count) + 1'b1)
        else begin
            $error("update_count did not step by one");
            assert_errors++;
        end

    correct_bound: assert property (@(posedge clk) disable iff (rst)
        correct_count <= update_count)
        else begin
            $error("correct_count above update_count");
            assert_errors++;
        end

endmodule : branch_predictor_checker

bind branch_predictor branch_predictor_checker #(.stat_width(stat_width)) i_checker (
    .clk(clk), .rst(rst),
    .pred_hit(pred_hit), .pred_kind(pred_kind), .pred_taken(pred_taken),
    .update_valid(update_valid), .update_count(update_count),
    .correct_count(correct_count)
);

// ==== verification/tb_branch_predictor.sv ====
`timescale 1ns/1ns

module tb_branch_predictor
    import bp_pkg::*;
();

    localparam int hist_bits  = 4;
    localparam int stat_width = 16;
    localparam int wait_limit = 20;   // cycles allowed for an update to be counted

    logic                  clk;
    logic                  rst;
    addr_t                 lookup_pc;
    logic                  pred_hit;
    addr_t                 pred_target;
    branch_kind_t          pred_kind;
    logic                  pred_taken;
    logic                  update_valid;
    addr_t                 update_pc;
    logic                  update_taken;
    addr_t                 update_target;
    branch_kind_t          update_kind;
    logic [stat_width-1:0] update_count;
    logic [stat_width-1:0] correct_count;

    logic [31:0] rng_state = 32'h55f0_3dc6;
    int unsigned pulses = 0;          // update strobes sent so far
    int unsigned errors = 0;
    int unsigned errors_before = 0;
    int unsigned passed_tests = 0;
    int unsigned failed_tests = 0;

    branch_predictor #(.hist_bits(hist_bits), .stat_width(stat_width)) i_branch_predictor (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic addr_t next_addr();
        return next_rand() & ~32'h3;   // word aligned
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("CHECK FAILED time %0t: %s expected %h, got %h", $time, name,
                     expected, actual);
            errors++;
        end
    endtask

    task automatic apply_lookup(input addr_t pc);
        @(posedge clk);
        #1 lookup_pc = pc;
        @(negedge clk);   // outputs settled by mid cycle
    endtask

    task automatic send_update(input addr_t pc, input logic tk, input addr_t tgt,
                               input branch_kind_t kd);
        int unsigned cycles;
        @(posedge clk);
        #1;
        update_valid  = 1'b1;
        update_pc     = pc;
        update_taken  = tk;
        update_target = tgt;
        update_kind   = kd;
        @(posedge clk);
        #1 update_valid = 1'b0;
        pulses++;
        cycles = 0;
        while (update_count != stat_width'(pulses) && cycles < wait_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (update_count != stat_width'(pulses)) begin
            $display("update %0d was not counted within %0d cycles", pulses, wait_limit);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        if (errors == errors_before) begin
            passed_tests++;
            $display("test %s: pass", name);
        end else begin
            failed_tests++;
            $display("test %s: fail with %0d errors", name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    initial begin
        addr_t       a;
        addr_t       b;
        addr_t       t;
        int unsigned expected_correct;
        rst           = 1'b1;
        lookup_pc     = '0;
        update_valid  = 1'b0;
        update_pc     = '0;
        update_taken  = 1'b0;
        update_target = '0;
        update_kind   = br;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;

        repeat (8) begin
            apply_lookup(next_addr());
            check("pred_hit", pred_hit, 0);
            check("pred_taken", pred_taken, 0);
        end
        check("update_count", update_count, 0);
        check("correct_count", correct_count, 0);
        report_test("reset state");

        a = next_addr();
        t = next_rand();
        send_update(a, 1'b1, t, jal);
        apply_lookup(a);
        check("pred_hit", pred_hit, 1);
        check("pred_kind", pred_kind, jal);
        check("pred_taken", pred_taken, 1);
        check("pred_target", pred_target, t);
        a = next_addr();
        t = next_rand() | 32'h1;   // odd target whose lsb must come back cleared
        send_update(a, 1'b1, t, jalr);
        apply_lookup(a);
        check("pred_hit", pred_hit, 1);
        check("pred_kind", pred_kind, jalr);
        check("pred_taken", pred_taken, 1);
        check("pred_target", pred_target, t & ~32'h1);
        report_test("jump targets");

        a = next_addr();
        b = a ^ 32'h8000_0000;   // same index but another tag
        send_update(a, 1'b1, next_rand(), jal);
        send_update(b, 1'b1, next_rand(), jal);
        apply_lookup(a);
        check("pred_hit", pred_hit, 0);
        apply_lookup(b);
        check("pred_hit", pred_hit, 1);
        report_test("tag conflict");

        a = next_addr();
        expected_correct = correct_count;
        repeat (4) begin
            send_update(a, 1'b0, a + 32'd64, br);
            expected_correct++;   // fresh counters guess not taken
            check("correct_count", correct_count, expected_correct);
        end
        apply_lookup(a);
        check("pred_hit", pred_hit, 1);
        check("pred_kind", pred_kind, br);
        check("pred_taken", pred_taken, 0);
        report_test("branch not taken");

        b = next_addr();
        repeat (hist_bits + 2) send_update(b, 1'b1, b - 32'd128, br);
        apply_lookup(b);
        check("pred_hit", pred_hit, 1);
        check("pred_taken", pred_taken, 1);
        check("pred_target", pred_target, b - 32'd128);
        report_test("branch taken");

        check("update_count", update_count, pulses);
        report_test("update count");

        $display("tests passed %0d, failed %0d, assertion failures %0d", passed_tests,
                 failed_tests, i_branch_predictor.i_checker.assert_errors);
        if (errors == 0 && i_branch_predictor.i_checker.assert_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : tb_branch_predictor
